/* axil_sim_mem.f */
hdl/axil_pkg.sv
hdl/strobe_ram.sv
hdl/axil_read_slave.sv
hdl/axil_write_slave.sv
hdl/axil_sim_mem.sv
dv/axil_sim_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the axil_sim_mem testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=axil_sim_mem_tb
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f axil_sim_mem.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

/* dv/axil_sim_mem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_sim_mem_tb
    import axil_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam logic [15:0] LFSR_SEED = 16'd59;
    localparam int ADDR_FIRST = 0;
    localparam int DATA_FIRST = 1;

    // rounds per test
    localparam int FULL_WRITES = 12;
    localparam int STROBE_ROUNDS = 8;
    localparam int ORDER_ROUNDS = 4;
    localparam int STALL_ROUNDS = 8;
    localparam int RANGE_ROUNDS = 4;
    localparam int TOTAL_ACCESSES = 2 * FULL_WRITES + 3 * STROBE_ROUNDS + 6 * ORDER_ROUNDS
                                  + 2 * STALL_ROUNDS + 4 * RANGE_ROUNDS;
    // handshakes, delay, longest stall of 7, slack
    localparam int ACCESS_CYCLES = 4 + ACCESS_DELAY + 7 + 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_ACCESSES * ACCESS_CYCLES;

    logic     clock;
    logic     reset;
    axil_ar_t ar;
    logic     arvalid;
    logic     arready;
    axil_r_t  r;
    logic     rvalid;
    logic     rready;
    axil_aw_t aw;
    logic     awvalid;
    logic     awready;
    axil_w_t  w;
    logic     wvalid;
    logic     wready;
    axil_b_t  b;
    logic     bvalid;
    logic     bready;

    logic [DATA_WIDTH-1:0] model [MEM_WORDS];
    logic [15:0]           lfsr_state;
    axil_r_t               exp_r;
    axil_b_t               exp_b;
    logic                  read_pending;
    logic                  write_pending;
    logic                  bvalid_prev;
    int                    error_count = 0;
    int                    errors_at_start = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    b_count = 0;
    int                    cycle_count;

    axil_sim_mem dut0 (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // each write response counted once as it is offered
    always @(posedge clock) begin
        if (reset) begin
            bvalid_prev <= 1'b0;
        end else begin
            bvalid_prev <= bvalid;
            if (bvalid && !bvalid_prev) begin
                b_count <= b_count + 1;
            end
        end
    end

    // responses against the model
    assert property (@(posedge clock) disable iff (reset) rvalid |-> r == exp_r)
        else begin
            error_count++;
            $display("ERROR r got %h expected %h", r, exp_r);
        end
    assert property (@(posedge clock) disable iff (reset) bvalid |-> b == exp_b)
        else begin
            error_count++;
            $display("ERROR b got %h expected %h", b, exp_b);
        end
    assert property (@(posedge clock) disable iff (reset)
                     arvalid && arready |-> ##(ACCESS_DELAY + 1) rvalid)
        else begin
            error_count++;
            $display("read response did not appear after the access delay");
        end

    // held responses under back-pressure
    assert property (@(posedge clock) disable iff (reset)
                     rvalid && !rready |=> rvalid && !arready && $stable(r))
        else begin
            error_count++;
            $display("read response dropped, changed or arready raised while held");
        end
    assert property (@(posedge clock) disable iff (reset)
                     bvalid && !bready |=> bvalid && $stable(b))
        else begin
            error_count++;
            $display("write response dropped or changed while held");
        end

    // one response per access
    assert property (@(posedge clock) disable iff (reset) rvalid |-> read_pending)
        else begin
            error_count++;
            $display("rvalid raised with no read outstanding");
        end
    assert property (@(posedge clock) disable iff (reset) bvalid |-> write_pending)
        else begin
            error_count++;
            $display("bvalid raised with no write outstanding");
        end
    assert property (@(posedge clock) disable iff (reset) bvalid && bready |=> !bvalid)
        else begin
            error_count++;
            $display("bvalid stayed high after the write response was taken");
        end

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            // taps 16 14 13 11
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_in_range();
        logic [31:0] bits;
        bits = random_bits(12);
        return {20'h0, bits[11:0]};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                           input logic [DATA_WIDTH-1:0] new_word,
                                                           input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int lane = 0; lane < STRB_WIDTH; lane++) begin
            if (strb[lane]) begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // raise the chosen valids at a falling edge, drop them after the transfer
    task automatic offer_write(input logic send_addr, input logic send_data);
        awvalid = send_addr;
        wvalid = send_data;
        while ((awvalid && !awready) || (wvalid && !wready)) @(negedge clock);
        @(negedge clock);
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                              input logic [STRB_WIDTH-1:0] strb, input int order, input int stall);
        logic in_range;
        in_range = (addr[ADDR_WIDTH-1:12] == '0);
        exp_b.resp = in_range ? RESP_OKAY : RESP_SLVERR;
        write_pending = 1'b1;
        aw.addr = addr;
        w.data = data;
        w.strb = strb;
        case (order)
            ADDR_FIRST: begin
                offer_write(1'b1, 1'b0);
                offer_write(1'b0, 1'b1);
            end
            DATA_FIRST: begin
                offer_write(1'b0, 1'b1);
                offer_write(1'b1, 1'b0);
            end
            default: offer_write(1'b1, 1'b1);
        endcase
        while (!bvalid) @(negedge clock);
        repeat (stall) @(negedge clock);
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
        write_pending = 1'b0;
        if (in_range) begin
            model[addr[11:2]] = merge_bytes(model[addr[11:2]], data, strb);
        end
    endtask

    task automatic read_word(input logic [ADDR_WIDTH-1:0] addr, input int stall);
        logic in_range;
        in_range = (addr[ADDR_WIDTH-1:12] == '0);
        exp_r.data = in_range ? model[addr[11:2]] : '0;
        exp_r.resp = in_range ? RESP_OKAY : RESP_SLVERR;
        read_pending = 1'b1;
        ar.addr = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clock);
        @(negedge clock);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clock);
        repeat (stall) @(negedge clock);
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
        read_pending = 1'b0;
    endtask

    task automatic end_test(input string name);
        int new_errors;
        new_errors = error_count - errors_at_start;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, new_errors);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles with tests still running", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addr_list [$];
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        int                    b_before;

        lfsr_state = LFSR_SEED;
        reset = 1'b1;
        ar = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        exp_r = '0;
        exp_b = '0;
        read_pending = 1'b0;
        write_pending = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        assert ({arready, awready, wready, rvalid, bvalid} == 5'b11100)
            else begin
                error_count++;
                $display("ERROR {arready,awready,wready,rvalid,bvalid} got %h expected %h",
                         {arready, awready, wready, rvalid, bvalid}, 5'b11100);
            end
        end_test("reset_state");

        for (int i = 0; i < FULL_WRITES; i++) begin
            addr = random_in_range();
            addr_list.push_back(addr);
            write_word(addr, random_bits(32), 4'hf, 2, 0);
        end
        foreach (addr_list[i]) begin
            read_word(addr_list[i], 0);
        end
        end_test("full_word");

        for (int i = 0; i < STROBE_ROUNDS; i++) begin
            addr = random_in_range();
            write_word(addr, random_bits(32), 4'hf, 2, 0);
            write_word(addr, random_bits(32), 4'(random_bits(4)), 2, 0);
            read_word(addr, 0);
        end
        end_test("byte_strobe");

        // same word through each ordering to neighboring addresses
        b_before = b_count;
        for (int i = 0; i < ORDER_ROUNDS; i++) begin
            addr = random_in_range();
            data = random_bits(32);
            for (int order = 0; order < 3; order++) begin
                write_word((addr + 32'(order * 4)) & 32'h0000_0fff, data, 4'hf, order, 0);
            end
            for (int order = 0; order < 3; order++) begin
                read_word((addr + 32'(order * 4)) & 32'h0000_0fff, 0);
            end
        end
        assert (b_count - b_before == 3 * ORDER_ROUNDS)
            else begin
                error_count++;
                $display("ERROR b_count got %h expected %h", b_count - b_before, 3 * ORDER_ROUNDS);
            end
        end_test("channel_order");

        for (int i = 0; i < STALL_ROUNDS; i++) begin
            addr = random_in_range();
            write_word(addr, random_bits(32), 4'hf, int'(random_bits(2)) % 3, int'(random_bits(3)));
            read_word(addr, int'(random_bits(3)));
        end
        end_test("back_pressure");

        for (int i = 0; i < RANGE_ROUNDS; i++) begin
            if (i == 0) begin
                addr = 32'h0000_1000;
            end else if (i == 1) begin
                addr = 32'hffff_fffc;
            end else begin
                addr = random_bits(32);
                addr[12] = 1'b1;
            end
            // seed the aliased word so a stray write would show
            write_word(addr & 32'h0000_0fff, random_bits(32), 4'hf, 2, 0);
            write_word(addr, random_bits(32), 4'hf, int'(random_bits(2)) % 3, 0);
            read_word(addr, 0);
            read_word(addr & 32'h0000_0fff, 0);
        end
        end_test("out_of_range");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/axil_sim_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_sim_mem
    import axil_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    // read address
    input  axil_ar_t ar,
    input  logic     arvalid,
    output logic     arready,
    // read data
    output axil_r_t  r,
    output logic     rvalid,
    input  logic     rready,
    // write address
    input  axil_aw_t aw,
    input  logic     awvalid,
    output logic     awready,
    // write data
    input  axil_w_t  w,
    input  logic     wvalid,
    output logic     wready,
    // write response
    output axil_b_t  b,
    output logic     bvalid,
    input  logic     bready
);

    logic                        rd_en;
    logic [WORD_INDEX_WIDTH-1:0] rd_index;
    logic [DATA_WIDTH-1:0]       rd_data;
    logic                        wr_en;
    logic [WORD_INDEX_WIDTH-1:0] wr_index;
    logic [DATA_WIDTH-1:0]       wr_data;
    logic [STRB_WIDTH-1:0]       wr_strb;

    axil_read_slave read_slave0 (
        .clock    (clock),
        .reset    (reset),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axil_write_slave write_slave0 (
        .clock    (clock),
        .reset    (reset),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .b        (b),
        .bvalid   (bvalid),
        .bready   (bready),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    // both channels share one word array
    strobe_ram ram0 (
        .clock    (clock),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

endmodule

`default_nettype wire

/* hdl/axil_write_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_write_slave
    import axil_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  axil_aw_t                    aw,
    input  logic                        awvalid,
    output logic                        awready,
    input  axil_w_t                     w,
    input  logic                        wvalid,
    output logic                        wready,
    output axil_b_t                     b,
    output logic                        bvalid,
    input  logic                        bready,
    output logic                        wr_en,
    output logic [WORD_INDEX_WIDTH-1:0] wr_index,
    output logic [DATA_WIDTH-1:0]       wr_data,
    output logic [STRB_WIDTH-1:0]       wr_strb
);

    typedef enum logic [2:0] {
        W_IDLE,
        W_WAIT_ADDR,
        W_WAIT_DATA,
        W_WRITE,
        W_RESP
    } w_state_t;

    w_state_t                     state;
    w_state_t                     state_next;
    logic [DELAY_COUNT_WIDTH-1:0] delay_count;
    logic                         aw_fire;
    logic                         w_fire;
    logic                         write_start;
    logic                         write_done;
    logic [WORD_INDEX_WIDTH-1:0]  index_q;
    logic                         in_range_q;
    axil_w_t                      w_q;
    axil_b_t                      b_q;

    assign awready = (state == W_IDLE) || (state == W_WAIT_ADDR);
    assign wready = (state == W_IDLE) || (state == W_WAIT_DATA);
    assign bvalid = (state == W_RESP);
    assign b = b_q;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;

    // second half of the pair arrived, or both on the same edge
    assign write_start = (state != W_WRITE) && (state_next == W_WRITE);
    assign write_done = (state == W_WRITE) && (delay_count == DELAY_LAST);

    // single enable pulse, dropped for an address outside the memory
    assign wr_en = write_done && in_range_q;
    assign wr_index = index_q;
    assign wr_data = w_q.data;
    assign wr_strb = w_q.strb;

    always_comb begin
        state_next = state;
        case (state)
            W_IDLE: begin
                if (awvalid && wvalid) begin
                    state_next = W_WRITE;
                end else if (awvalid) begin
                    state_next = W_WAIT_DATA;
                end else if (wvalid) begin
                    state_next = W_WAIT_ADDR;
                end
            end
            W_WAIT_ADDR: if (awvalid) state_next = W_WRITE;
            W_WAIT_DATA: if (wvalid) state_next = W_WRITE;
            W_WRITE:     if (write_done) state_next = W_RESP;
            W_RESP:      if (bready) state_next = W_IDLE;
            default:     state_next = W_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= W_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            delay_count <= '0;
        end else if (write_start) begin
            delay_count <= DELAY_COUNT_WIDTH'(1);
        end else if ((state == W_WRITE) && !write_done) begin
            delay_count <= delay_count + 1'b1;
        end
    end

    // address and data latch independently as each one arrives
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            index_q <= word_index(aw.addr);
            in_range_q <= addr_in_range(aw.addr);
        end
        if (w_fire) begin
            w_q <= w;
        end
    end

    always_ff @(posedge clock) begin
        if (write_done) begin
            b_q.resp <= in_range_q ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

/* hdl/axil_read_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_read_slave
    import axil_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  axil_ar_t                    ar,
    input  logic                        arvalid,
    output logic                        arready,
    output axil_r_t                     r,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        rd_en,
    output logic [WORD_INDEX_WIDTH-1:0] rd_index,
    input  logic [DATA_WIDTH-1:0]       rd_data
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACCESS,
        R_RESP
    } r_state_t;

    r_state_t                     state;
    r_state_t                     state_next;
    logic [DELAY_COUNT_WIDTH-1:0] delay_count;
    logic                         access_done;
    logic [WORD_INDEX_WIDTH-1:0]  index_q;
    logic                         in_range_q;
    axil_r_t                      r_q;

    assign arready = (state == R_IDLE);
    assign rvalid = (state == R_RESP);
    assign r = r_q;

    // last cycle of the modeled access
    assign access_done = (state == R_ACCESS) && (delay_count == DELAY_LAST);

    assign rd_en = access_done && in_range_q;
    assign rd_index = index_q;

    always_comb begin
        state_next = state;
        case (state)
            R_IDLE:   if (arvalid) state_next = R_ACCESS;
            R_ACCESS: if (access_done) state_next = R_RESP;
            R_RESP:   if (rready) state_next = R_IDLE;
            default:  state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= R_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // counts from 1 on the capture edge
    always_ff @(posedge clock) begin
        if (reset) begin
            delay_count <= '0;
        end else if (arready && arvalid) begin
            delay_count <= DELAY_COUNT_WIDTH'(1);
        end else if ((state == R_ACCESS) && !access_done) begin
            delay_count <= delay_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (arready && arvalid) begin
            index_q <= word_index(ar.addr);
            in_range_q <= addr_in_range(ar.addr);
        end
    end

    // response is loaded once and held until rready
    always_ff @(posedge clock) begin
        if (access_done) begin
            if (in_range_q) begin
                r_q.data <= rd_data;
                r_q.resp <= RESP_OKAY;
            end else begin
                r_q.data <= '0;
                r_q.resp <= RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/strobe_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module strobe_ram
    import axil_pkg::*;
(
    input  logic                        clock,
    input  logic                        rd_en,
    input  logic [WORD_INDEX_WIDTH-1:0] rd_index,
    output logic [DATA_WIDTH-1:0]       rd_data,
    input  logic                        wr_en,
    input  logic [WORD_INDEX_WIDTH-1:0] wr_index,
    input  logic [DATA_WIDTH-1:0]       wr_data,
    input  logic [STRB_WIDTH-1:0]       wr_strb
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    // contents start at zero, reset leaves them alone
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // asynchronous read, zero when not enabled
    assign rd_data = rd_en ? mem[rd_index] : '0;

    // byte lanes update only where the strobe is set
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int lane = 0; lane < STRB_WIDTH; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_index][lane*BYTE_WIDTH +: BYTE_WIDTH] <=
                        wr_data[lane*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;
    localparam int BYTE_WIDTH = DATA_WIDTH / STRB_WIDTH;

    // 1024 words cover byte addresses 0 to 0xfff
    localparam int MEM_WORDS = 1024;
    localparam int WORD_INDEX_WIDTH = 10;
    // low address bits select a byte within the word
    localparam int WORD_LSB = 2;

    // modeled memory latency in cycles
    localparam int ACCESS_DELAY = 2;
    localparam int DELAY_COUNT_WIDTH = 5;
    localparam logic [DELAY_COUNT_WIDTH-1:0] DELAY_LAST = DELAY_COUNT_WIDTH'(ACCESS_DELAY);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    // word index is address bits 11:2
    function automatic logic [WORD_INDEX_WIDTH-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
        return addr[WORD_LSB +: WORD_INDEX_WIDTH];
    endfunction

    // in range when nothing is set above the memory window
    function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] addr);
        return addr[ADDR_WIDTH-1:WORD_LSB+WORD_INDEX_WIDTH] == '0;
    endfunction

endpackage

`default_nettype wire
